// File: bpu_cfg_pkg.sv
`default_nettype none

package bpu_cfg_pkg;

    // table geometry
    localparam int UBTB_SIZE  = 8;
    localparam int UBTB_IDX_W = $clog2(UBTB_SIZE);
    localparam int UBTB_TAG_W = 12;

    localparam int SLOT_NUM   = 2;
    localparam int SLOT_IDX_W = $clog2(SLOT_NUM); // width of the taken slot index

    // fetch block geometry
    localparam int VADDR_W     = 32;
    localparam int INST_OFFSET = 2;  // byte bits below one instruction
    localparam int BLOCK_SIZE  = 32;
    localparam int OFFSET_W    = 3;  // instruction index within a block

    // byte offset bits of a block, the tag starts right above them
    localparam int BLOCK_OFF_W = INST_OFFSET + OFFSET_W;

    // offset of the last instruction in a block
    localparam logic [OFFSET_W-1:0] LAST_OFFSET =
        OFFSET_W'((BLOCK_SIZE >> INST_OFFSET) - 1);

    // counter encodings
    localparam logic [1:0] CTR_WEAK_TAKEN = 2'b10;
    localparam logic [1:0] CTR_MAX        = 2'b11;
    localparam logic [1:0] CTR_MIN        = 2'b00;

endpackage

`default_nettype wire

// File: bpu_types_pkg.sv
`default_nettype none

package bpu_types_pkg;

    typedef enum logic {
        BR_COND = 1'b0, // conditional, predicted by its counter
        BR_JUMP = 1'b1  // unconditional, always taken
    } br_type_e;

    // one branch slot of a BTB entry
    typedef struct packed {
        logic                                en;
        logic [bpu_cfg_pkg::OFFSET_W-1:0]    offset;
        br_type_e                            br_type;
        logic [bpu_cfg_pkg::VADDR_W-1:0]     target;
    } btb_slot_t;

    // slot 0 is the earlier branch in the block
    typedef btb_slot_t [bpu_cfg_pkg::SLOT_NUM-1:0] btb_entry_t;

    // per slot 2-bit saturating counters
    typedef logic [bpu_cfg_pkg::SLOT_NUM-1:0][1:0] ctr_vec_t;

    // commit time update request
    typedef struct packed {
        logic [bpu_cfg_pkg::VADDR_W-1:0]     start_addr;
        btb_entry_t                          entry;
        logic [bpu_cfg_pkg::SLOT_NUM-1:0]    alloc;  // slot was newly allocated
        logic [bpu_cfg_pkg::SLOT_NUM-1:0]    taken;  // resolved direction
    } ubtb_update_t;

    // same cycle prediction
    typedef struct packed {
        logic                                valid;
        logic                                hit;
        logic                                taken;
        logic [bpu_cfg_pkg::SLOT_IDX_W-1:0]  taken_slot;
        logic [bpu_cfg_pkg::VADDR_W-1:0]     target;
        logic [bpu_cfg_pkg::OFFSET_W-1:0]    size;
    } ubtb_result_t;

endpackage

`default_nettype wire

// File: ubtb_update_front.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_update_front (
    input  logic                                 update_i,
    input  bpu_types_pkg::ubtb_update_t          update_info_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    update_hit_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    victim_way_i,
    output logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    wr_way_o,
    output logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]   upd_tag_o,
    output logic [bpu_cfg_pkg::SLOT_NUM-1:0]     slot_train_o,
    output logic [bpu_cfg_pkg::SLOT_NUM-1:0]     slot_alloc_o,
    output bpu_types_pkg::btb_entry_t            upd_entry_o
);

    logic                                upd_hit;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   sel_way;

    // tag sits right above the block offset, same slice as the lookup side
    assign upd_tag_o = update_info_i.start_addr[bpu_cfg_pkg::BLOCK_OFF_W +: bpu_cfg_pkg::UBTB_TAG_W];

    assign upd_hit = |update_hit_i;

    // an existing tag is rewritten in place, otherwise the PLRU victim is refilled
    assign sel_way  = upd_hit ? update_hit_i : victim_way_i;
    assign wr_way_o = update_i ? sel_way : '0;

    always_comb begin
        for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
            // only enabled conditional slots own a counter worth training
            slot_train_o[s] = update_i
                            & update_info_i.entry[s].en
                            & (update_info_i.entry[s].br_type == bpu_types_pkg::BR_COND);
            slot_alloc_o[s] = slot_train_o[s] & update_info_i.alloc[s];
        end
    end

    assign upd_entry_o = update_info_i.entry;

endmodule

`default_nettype wire

// File: ubtb_way.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_way (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]   lookup_tag_i,
    input  logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]   upd_tag_i,
    input  logic                                 wr_i,
    input  bpu_types_pkg::btb_entry_t            upd_entry_i,
    input  logic [bpu_cfg_pkg::SLOT_NUM-1:0]     slot_train_i,
    input  logic [bpu_cfg_pkg::SLOT_NUM-1:0]     slot_alloc_i,
    input  logic [bpu_cfg_pkg::SLOT_NUM-1:0]     taken_i,
    output logic                                 lookup_hit_o,
    output logic                                 update_hit_o,
    output bpu_types_pkg::btb_entry_t            entry_o,
    output bpu_types_pkg::ctr_vec_t              ctr_o
);

    logic                                valid_q;
    logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]  tag_q;
    bpu_types_pkg::btb_entry_t           entry_q;
    bpu_types_pkg::ctr_vec_t             ctr_q;
    bpu_types_pkg::ctr_vec_t             ctr_d;

    function automatic logic [1:0] sat_step(input logic [1:0] ctr, input logic taken);
        if (taken) begin
            return (ctr == bpu_cfg_pkg::CTR_MAX) ? ctr : ctr + 2'd1;
        end
        return (ctr == bpu_cfg_pkg::CTR_MIN) ? ctr : ctr - 2'd1;
    endfunction

    assign lookup_hit_o = valid_q && (tag_q == lookup_tag_i);
    assign update_hit_o = valid_q && (tag_q == upd_tag_i);

    always_comb begin
        logic [1:0] base;
        for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
            base = update_hit_o ? ctr_q[s] : 2'b00; // a replaced tag starts from zero
            if (slot_train_i[s]) begin
                ctr_d[s] = slot_alloc_i[s] ? bpu_cfg_pkg::CTR_WEAK_TAKEN : sat_step(base, taken_i[s]);
            end else begin
                ctr_d[s] = base;
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid_q <= 1'b0;
            ctr_q   <= '0;
        end else if (wr_i) begin
            valid_q <= 1'b1;
            ctr_q   <= ctr_d;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i) begin
            tag_q   <= upd_tag_i;
            entry_q <= upd_entry_i;
        end
    end

    assign entry_o = entry_q;
    assign ctr_o   = ctr_q;

endmodule

`default_nettype wire

// File: ubtb_plru.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_plru (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 touch_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    touch_way_i,
    output logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    victim_way_o
);

    // heap ordered tree, node n has children 2n+1 and 2n+2
    // a node bit of 1 sends the victim search to the right half
    logic [bpu_cfg_pkg::UBTB_SIZE-2:0]   tree_q;
    logic [bpu_cfg_pkg::UBTB_SIZE-2:0]   tree_d;
    logic [bpu_cfg_pkg::UBTB_IDX_W-1:0]  touch_idx;
    logic [bpu_cfg_pkg::UBTB_IDX_W-1:0]  victim_idx;

    always_comb begin
        touch_idx = '0;
        for (int i = 0; i < bpu_cfg_pkg::UBTB_SIZE; i++) begin
            if (touch_way_i[i]) touch_idx = bpu_cfg_pkg::UBTB_IDX_W'(i);
        end
    end

    always_comb begin
        int  node;
        logic dir;
        node   = 0;
        tree_d = tree_q;
        for (int l = 0; l < bpu_cfg_pkg::UBTB_IDX_W; l++) begin
            dir          = touch_idx[bpu_cfg_pkg::UBTB_IDX_W-1-l];
            tree_d[node] = ~dir; // point away from the touched half
            node         = 2 * node + 1 + int'(dir);
        end
    end

    always_comb begin
        int  node;
        logic dir;
        node       = 0;
        victim_idx = '0;
        for (int l = 0; l < bpu_cfg_pkg::UBTB_IDX_W; l++) begin
            dir = tree_q[node];
            victim_idx[bpu_cfg_pkg::UBTB_IDX_W-1-l] = dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

    assign victim_way_o = bpu_cfg_pkg::UBTB_SIZE'(1) << victim_idx;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            tree_q <= '0;
        end else if (touch_i) begin
            tree_q <= tree_d;
        end
    end

endmodule

`default_nettype wire

// File: ubtb_predict.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_predict (
    input  logic                                 lookup_en_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0]      lookup_pc_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    lookup_hits_i,
    input  bpu_types_pkg::btb_entry_t            entries_i [bpu_cfg_pkg::UBTB_SIZE],
    input  bpu_types_pkg::ctr_vec_t              ctrs_i [bpu_cfg_pkg::UBTB_SIZE],
    output bpu_types_pkg::ubtb_result_t          result_o
);

    logic [bpu_cfg_pkg::UBTB_IDX_W-1:0]  hit_idx;
    logic                                hit;
    bpu_types_pkg::btb_entry_t           hit_entry;
    bpu_types_pkg::ctr_vec_t             hit_ctr;
    logic [bpu_cfg_pkg::SLOT_NUM-1:0]    slot_taken;
    logic                                any_taken;
    logic [bpu_cfg_pkg::SLOT_IDX_W-1:0]  first_slot;
    logic [bpu_cfg_pkg::VADDR_W-1:0]     fall_through;

    // the hit vector is at most one-hot, so an OR of indices is enough
    always_comb begin
        hit_idx = '0;
        for (int i = 0; i < bpu_cfg_pkg::UBTB_SIZE; i++) begin
            if (lookup_hits_i[i]) hit_idx = hit_idx | bpu_cfg_pkg::UBTB_IDX_W'(i);
        end
    end

    assign hit       = lookup_en_i & (|lookup_hits_i);
    assign hit_entry = entries_i[hit_idx];
    assign hit_ctr   = ctrs_i[hit_idx];

    always_comb begin
        for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
            slot_taken[s] = hit_entry[s].en
                          & ((hit_entry[s].br_type == bpu_types_pkg::BR_JUMP) | hit_ctr[s][1]);
        end
    end

    // earliest taken slot in program order wins
    always_comb begin
        any_taken  = 1'b0;
        first_slot = '0;
        for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
            if (!any_taken && slot_taken[s]) begin
                any_taken  = 1'b1;
                first_slot = bpu_cfg_pkg::SLOT_IDX_W'(s);
            end
        end
    end

    assign fall_through = {lookup_pc_i[bpu_cfg_pkg::VADDR_W-1:bpu_cfg_pkg::BLOCK_OFF_W],
                           {bpu_cfg_pkg::BLOCK_OFF_W{1'b0}}}
                        + bpu_cfg_pkg::VADDR_W'(bpu_cfg_pkg::BLOCK_SIZE);

    always_comb begin
        result_o            = '0;
        result_o.valid      = lookup_en_i;
        result_o.hit        = hit;
        result_o.target     = fall_through;
        result_o.size       = bpu_cfg_pkg::LAST_OFFSET;
        if (hit && any_taken) begin
            result_o.taken      = 1'b1;
            result_o.taken_slot = first_slot;
            result_o.target     = hit_entry[first_slot].target;
            result_o.size       = hit_entry[first_slot].offset;
        end
    end

endmodule

`default_nettype wire

// File: ubtb_top.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_top (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 lookup_en_i,
    input  logic [bpu_cfg_pkg::VADDR_W-1:0]      lookup_pc_i,
    input  logic                                 update_i,
    input  bpu_types_pkg::ubtb_update_t          update_info_i,
    output bpu_types_pkg::ubtb_result_t          result_o
);

    logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]  lookup_tag;
    logic [bpu_cfg_pkg::UBTB_TAG_W-1:0]  upd_tag;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   lookup_hits;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   update_hits;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   wr_way;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   victim_way;
    logic [bpu_cfg_pkg::UBTB_SIZE-1:0]   touch_way;
    logic [bpu_cfg_pkg::SLOT_NUM-1:0]    slot_train;
    logic [bpu_cfg_pkg::SLOT_NUM-1:0]    slot_alloc;
    bpu_types_pkg::btb_entry_t           upd_entry;
    bpu_types_pkg::btb_entry_t           way_entry [bpu_cfg_pkg::UBTB_SIZE];
    bpu_types_pkg::ctr_vec_t             way_ctr [bpu_cfg_pkg::UBTB_SIZE];

    assign lookup_tag = lookup_pc_i[bpu_cfg_pkg::BLOCK_OFF_W +: bpu_cfg_pkg::UBTB_TAG_W];

    // updates take priority over lookups for the replacement state
    assign touch_way = update_i ? wr_way : (lookup_en_i ? lookup_hits : '0);

    ubtb_update_front u_front (
        .update_i      (update_i),
        .update_info_i (update_info_i),
        .update_hit_i  (update_hits),
        .victim_way_i  (victim_way),
        .wr_way_o      (wr_way),
        .upd_tag_o     (upd_tag),
        .slot_train_o  (slot_train),
        .slot_alloc_o  (slot_alloc),
        .upd_entry_o   (upd_entry)
    );

    for (genvar w = 0; w < bpu_cfg_pkg::UBTB_SIZE; w++) begin : g_way
        ubtb_way u_way (
            .clk          (clk),
            .rst          (rst),
            .lookup_tag_i (lookup_tag),
            .upd_tag_i    (upd_tag),
            .wr_i         (wr_way[w]),
            .upd_entry_i  (upd_entry),
            .slot_train_i (slot_train),
            .slot_alloc_i (slot_alloc),
            .taken_i      (update_info_i.taken),
            .lookup_hit_o (lookup_hits[w]),
            .update_hit_o (update_hits[w]),
            .entry_o      (way_entry[w]),
            .ctr_o        (way_ctr[w])
        );
    end

    ubtb_plru u_plru (
        .clk          (clk),
        .rst          (rst),
        .touch_i      (|touch_way),
        .touch_way_i  (touch_way),
        .victim_way_o (victim_way)
    );

    ubtb_predict u_predict (
        .lookup_en_i   (lookup_en_i),
        .lookup_pc_i   (lookup_pc_i),
        .lookup_hits_i (lookup_hits),
        .entries_i     (way_entry),
        .ctrs_i        (way_ctr),
        .result_o      (result_o)
    );

endmodule

`default_nettype wire

// File: ubtb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_asserts (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 lookup_en_i,
    input  logic                                 update_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    lookup_hits_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    update_hits_i,
    input  logic [bpu_cfg_pkg::UBTB_SIZE-1:0]    wr_way_i,
    input  bpu_types_pkg::ubtb_result_t          result_i
);

    int fail_cnt = 0; // read by the testbench at the end of the run

    // a tag lives in at most one way
    a_lookup_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(lookup_hits_i))
        else begin
            $error("lookup hit vector has more than one way set");
            fail_cnt = fail_cnt + 1;
        end

    a_update_onehot: assert property (@(posedge clk) disable iff (!rst)
        $onehot0(update_hits_i))
        else begin
            $error("update hit vector has more than one way set");
            fail_cnt = fail_cnt + 1;
        end

    a_wr_onehot: assert property (@(posedge clk) disable iff (!rst)
        update_i |-> $onehot(wr_way_i))
        else begin
            $error("update strobe without exactly one write way");
            fail_cnt = fail_cnt + 1;
        end

    a_wr_idle: assert property (@(posedge clk) disable iff (!rst)
        !update_i |-> (wr_way_i == '0))
        else begin
            $error("write way set without an update strobe");
            fail_cnt = fail_cnt + 1;
        end

    a_valid: assert property (@(posedge clk) disable iff (!rst)
        result_i.valid == lookup_en_i)
        else begin
            $error("result valid does not follow the lookup enable");
            fail_cnt = fail_cnt + 1;
        end

    a_hit_en: assert property (@(posedge clk) disable iff (!rst)
        result_i.hit |-> lookup_en_i)
        else begin
            $error("result hit without a lookup");
            fail_cnt = fail_cnt + 1;
        end

endmodule

bind ubtb_top ubtb_asserts u_asserts (
    .clk           (clk),
    .rst           (rst),
    .lookup_en_i   (lookup_en_i),
    .update_i      (update_i),
    .lookup_hits_i (lookup_hits),
    .update_hits_i (update_hits),
    .wr_way_i      (wr_way),
    .result_i      (result_o)
);

`default_nettype wire

// File: ubtb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ubtb_tb;

    // two cycles per lookup or update and six per reset over all five tests
    localparam int TEST_CYCLES    = 22 + 4 + 36 + 4 + 62;
    localparam int TIMEOUT_CYCLES = 4 * TEST_CYCLES;

    logic                                clk = 1'b0;
    logic                                rst;
    logic                                lookup_en_i;
    logic [bpu_cfg_pkg::VADDR_W-1:0]     lookup_pc_i;
    logic                                update_i;
    bpu_types_pkg::ubtb_update_t         update_info_i;
    bpu_types_pkg::ubtb_result_t         result_o;

    // reference table keyed by tag
    bpu_types_pkg::btb_entry_t           model_entry [int];
    bpu_types_pkg::ctr_vec_t             model_ctr [int];

    logic [15:0]                         lfsr_state = 16'd21;
    int                                  cycle_cnt = 0;
    int                                  checks = 0;
    int                                  errors = 0;
    int                                  tests = 0;
    int                                  test_checks;
    int                                  test_errors;
    string                               test_name;

    ubtb_top u_dut (
        .clk           (clk),
        .rst           (rst),
        .lookup_en_i   (lookup_en_i),
        .lookup_pc_i   (lookup_pc_i),
        .update_i      (update_i),
        .update_info_i (update_info_i),
        .result_o      (result_o)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Done: errors found");
            $finish;
        end
    end

    // taps of x^16 + x^14 + x^13 + x^11 + 1 with one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb         = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
            lfsr_state = {lfsr_state[14:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    function automatic int tag_of(input logic [bpu_cfg_pkg::VADDR_W-1:0] pc);
        return int'(pc[bpu_cfg_pkg::BLOCK_OFF_W +: bpu_cfg_pkg::UBTB_TAG_W]);
    endfunction

    function automatic logic [31:0] make_pc(input logic [bpu_cfg_pkg::UBTB_TAG_W-1:0] tag);
        logic [31:0] pc;
        pc = rand_bits(32);
        pc[bpu_cfg_pkg::BLOCK_OFF_W +: bpu_cfg_pkg::UBTB_TAG_W] = tag;
        return pc;
    endfunction

    function automatic bpu_types_pkg::btb_slot_t rand_slot(input bpu_types_pkg::br_type_e kind);
        bpu_types_pkg::btb_slot_t s;
        s.en      = 1'b1;
        s.br_type = kind;
        s.offset  = bpu_cfg_pkg::OFFSET_W'(rand_bits(bpu_cfg_pkg::OFFSET_W));
        s.target  = rand_bits(bpu_cfg_pkg::VADDR_W);
        s.target[bpu_cfg_pkg::INST_OFFSET-1:0] = '0;
        return s;
    endfunction

    // what a lookup of pc has to return according to the reference table
    function automatic bpu_types_pkg::ubtb_result_t model_predict(input logic [31:0] pc);
        bpu_types_pkg::ubtb_result_t r;
        bpu_types_pkg::btb_entry_t   e;
        bpu_types_pkg::ctr_vec_t     c;
        r        = '0;
        r.valid  = 1'b1;
        r.target = {pc[31:bpu_cfg_pkg::BLOCK_OFF_W], {bpu_cfg_pkg::BLOCK_OFF_W{1'b0}}} + 32'd32;
        r.size   = bpu_cfg_pkg::OFFSET_W'((bpu_cfg_pkg::BLOCK_SIZE >> 2) - 1);
        if (model_entry.exists(tag_of(pc))) begin
            e     = model_entry[tag_of(pc)];
            c     = model_ctr[tag_of(pc)];
            r.hit = 1'b1;
            for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
                if (!r.taken && e[s].en
                    && (e[s].br_type == bpu_types_pkg::BR_JUMP || c[s][1])) begin
                    r.taken      = 1'b1;
                    r.taken_slot = bpu_cfg_pkg::SLOT_IDX_W'(s);
                    r.target     = e[s].target;
                    r.size       = e[s].offset;
                end
            end
        end
        return r;
    endfunction

    task automatic model_update(input bpu_types_pkg::ubtb_update_t u);
        bpu_types_pkg::ctr_vec_t c;
        c = '0; // a new tag starts from cleared counters
        if (model_entry.exists(tag_of(u.start_addr))) c = model_ctr[tag_of(u.start_addr)];
        for (int s = 0; s < bpu_cfg_pkg::SLOT_NUM; s++) begin
            if (u.entry[s].en && u.entry[s].br_type == bpu_types_pkg::BR_COND) begin
                if (u.alloc[s]) c[s] = 2'b10;
                else if (u.taken[s]) c[s] = (c[s] == 2'b11) ? c[s] : c[s] + 2'd1;
                else c[s] = (c[s] == 2'b00) ? c[s] : c[s] - 2'd1;
            end
        end
        model_entry[tag_of(u.start_addr)] = u.entry;
        model_ctr[tag_of(u.start_addr)]   = c;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b1;
        model_entry.delete();
        model_ctr.delete();
    endtask

    task automatic drive_update(input bpu_types_pkg::ubtb_update_t u);
        @(posedge clk);
        update_i      <= 1'b1;
        update_info_i <= u;
        @(posedge clk);
        update_i <= 1'b0; // written on this edge
        model_update(u);
    endtask

    task automatic drive_lookup(input logic [31:0] pc, output bpu_types_pkg::ubtb_result_t act);
        @(posedge clk);
        lookup_en_i <= 1'b1;
        lookup_pc_i <= pc;
        @(negedge clk);
        act = result_o;
        @(posedge clk);
        lookup_en_i <= 1'b0;
    endtask

    task automatic check_result(input bpu_types_pkg::ubtb_result_t expected,
                                input bpu_types_pkg::ubtb_result_t actual);
        checks++;
        test_checks++;
        assert (actual == expected) else begin
            $display("FAIL %s expected %h actual %h", test_name, expected, actual);
            errors++;
            test_errors++;
        end
    endtask

    task automatic lookup_and_check(input logic [31:0] pc);
        bpu_types_pkg::ubtb_result_t act;
        drive_lookup(pc, act);
        check_result(model_predict(pc), act);
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_checks = 0;
        test_errors = 0;
    endtask

    task automatic end_test();
        tests++;
        $display("%s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    endtask

    initial begin
        bpu_types_pkg::ubtb_update_t u;
        bpu_types_pkg::ubtb_result_t act;
        logic [31:0]                 pcs [9];
        logic [7:0]                  outcomes;
        int                          misses;
        int                          evicted;
        rst           <= 1'b0;
        lookup_en_i   <= 1'b0;
        lookup_pc_i   <= '0;
        update_i      <= 1'b0;
        update_info_i <= '0;

        start_test("reset_miss");
        apply_reset();
        for (int i = 0; i < 8; i++) lookup_and_check(rand_bits(32));
        end_test();

        start_test("alloc_taken");
        u            = '0;
        u.start_addr = make_pc(12'h0a1);
        u.entry[0]   = rand_slot(bpu_types_pkg::BR_COND);
        u.alloc      = 2'b01;
        drive_update(u);
        lookup_and_check(u.start_addr);
        end_test();

        start_test("counter_train");
        u.start_addr = make_pc(12'h0b2);
        u.entry[0]   = rand_slot(bpu_types_pkg::BR_COND);
        drive_update(u);
        lookup_and_check(u.start_addr);
        outcomes = 8'b0111_1000; // three not taken, four taken, one not taken
        u.alloc  = 2'b00;
        for (int i = 0; i < 8; i++) begin
            u.taken = {1'b0, outcomes[i]};
            drive_update(u);
            lookup_and_check(u.start_addr);
        end
        end_test();

        start_test("jump_slot1");
        u            = '0;
        u.start_addr = make_pc(12'h0c3);
        u.entry[0]   = rand_slot(bpu_types_pkg::BR_COND);
        u.entry[1]   = rand_slot(bpu_types_pkg::BR_JUMP);
        drive_update(u);
        lookup_and_check(u.start_addr);
        end_test();

        start_test("replacement");
        apply_reset();
        for (int i = 0; i < 9; i++) pcs[i] = make_pc(12'h200 + 12'(i * 37));
        for (int i = 0; i < 8; i++) begin
            u            = '0;
            u.start_addr = pcs[i];
            u.entry[0]   = rand_slot(bpu_types_pkg::BR_COND);
            u.alloc      = 2'b01;
            drive_update(u);
        end
        u.start_addr = pcs[2]; // the same tag again is rewritten in place
        u.entry[0]   = rand_slot(bpu_types_pkg::BR_COND);
        u.alloc      = 2'b00;
        u.taken      = 2'b01;
        drive_update(u);
        for (int i = 0; i < 8; i++) lookup_and_check(pcs[i]);
        lookup_and_check(pcs[5]);
        u.start_addr = pcs[8];
        u.alloc      = 2'b01;
        drive_update(u);
        misses  = 0;
        evicted = -1;
        for (int i = 0; i < 8; i++) begin
            drive_lookup(pcs[i], act);
            if (!act.hit) begin
                misses++;
                evicted = i;
                model_entry.delete(tag_of(pcs[i]));
                model_ctr.delete(tag_of(pcs[i]));
            end
            check_result(model_predict(pcs[i]), act);
        end
        checks      += 2;
        test_checks += 2;
        assert (misses == 1) else begin
            $display("FAIL %s evicted tags expected 1 actual %0d", test_name, misses);
            errors++;
            test_errors++;
        end
        assert (evicted != 5) else begin
            $display("%s: the most recently looked up tag was evicted", test_name);
            errors++;
            test_errors++;
        end
        lookup_and_check(pcs[8]);
        end_test();

        $display("%0d tests, %0d checks, %0d errors, %0d assertion failures",
                 tests, checks, errors, u_dut.u_asserts.fail_cnt);
        if (errors == 0 && u_dut.u_asserts.fail_cnt == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
bpu_cfg_pkg.sv
bpu_types_pkg.sv
ubtb_update_front.sv
ubtb_way.sv
ubtb_plru.sv
ubtb_predict.sv
ubtb_top.sv
ubtb_asserts.sv
ubtb_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile and run the uBTB testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module ubtb_tb -f project.f -o vsim
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

./obj_dir/vsim +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
